// ==== weight_pkg.sv ====
package weight_pkg;

  // Memory geometry
  localparam int W_DATA_WIDTH = 8;
  localparam int R_DATA_WIDTH = 32;  // Four byte lanes
  localparam int R_DEPTH      = 16;
  localparam int W_DEPTH      = R_DEPTH * R_DATA_WIDTH / W_DATA_WIDTH;
  localparam int W_ADDR_WIDTH = $clog2(W_DEPTH);
  localparam int R_ADDR_WIDTH = $clog2(R_DEPTH);

  localparam int RD_LATENCY   = 2;   // Default read pipeline depth
  localparam int SUM_WIDTH    = 16;  // Holds every lane of a full run

  typedef enum logic {
    OP_STREAM,
    OP_SUM
  } rd_op_e;

  typedef enum logic {
    LD_IDLE,
    LD_RUN
  } load_state_e;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ISSUE,
    RD_DRAIN
  } read_state_e;

  // One narrow write into the shell
  typedef struct packed {
    logic                    en;
    logic [W_ADDR_WIDTH-1:0] addr;
    logic [W_DATA_WIDTH-1:0] data;
  } wr_req_t;

  // Read command, count runs from 1 to R_DEPTH
  typedef struct packed {
    rd_op_e                  op;
    logic [R_ADDR_WIDTH-1:0] addr;
    logic [R_ADDR_WIDTH:0]   count;
  } rd_cmd_t;

endpackage

// ==== n_delay.sv ====
module n_delay #(
  parameter int N          = 2,
  parameter int WORD_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  clken,
  input  logic [WORD_WIDTH-1:0] data_in,
  output logic [WORD_WIDTH-1:0] data_out
);

  generate
    if (N == 0) begin : g_direct
      assign data_out = data_in;
    end else begin : g_pipe
      logic [N-1:0][WORD_WIDTH-1:0] stage;

      // Whole chain holds while clken is low
      always_ff @(posedge clk) begin
        if (!rst_n) begin
          stage <= '0;
        end else if (clken) begin
          stage[0] <= data_in;
          for (int i = 1; i < N; i++) begin
            stage[i] <= stage[i-1];
          end
        end
      end

      assign data_out = stage[N-1];  // Oldest entry
    end
  endgenerate

endmodule

// ==== weight_loader.sv ====
module weight_loader (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                load_start,
  input  logic [weight_pkg::W_ADDR_WIDTH-1:0] load_base,
  input  logic [weight_pkg::W_ADDR_WIDTH:0]   load_count,
  input  logic                                in_valid,
  input  logic [weight_pkg::W_DATA_WIDTH-1:0] in_data,
  output weight_pkg::wr_req_t                 wr,
  output logic                                load_done
);

  import weight_pkg::*;

  load_state_e             state;
  logic [W_ADDR_WIDTH-1:0] addr;       // Next write address
  logic [W_ADDR_WIDTH:0]   remaining;  // Bytes still expected
  logic [W_ADDR_WIDTH-1:0] addr_next;
  logic                    take;

  logic                    wr_en;
  logic                    wr_last;    // Registered write is the final byte
  logic [W_ADDR_WIDTH-1:0] wr_addr;
  logic [W_DATA_WIDTH-1:0] wr_data;

  assign take      = (state == LD_RUN) && in_valid;
  assign addr_next = (addr == W_ADDR_WIDTH'(W_DEPTH - 1)) ? '0 : addr + 1'b1;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= LD_IDLE;
      addr      <= '0;
      remaining <= '0;
      wr_en     <= 1'b0;
      wr_last   <= 1'b0;
      load_done <= 1'b0;
    end else begin
      wr_en     <= 1'b0;
      wr_last   <= 1'b0;
      load_done <= wr_en && wr_last;  // Same edge that stores the last byte
      case (state)
        LD_IDLE: begin
          if (load_start) begin
            addr      <= load_base;
            remaining <= load_count;
            if (load_count == '0) begin
              load_done <= 1'b1;  // Nothing to load
            end else begin
              state <= LD_RUN;
            end
          end
        end
        LD_RUN: begin
          if (in_valid) begin
            wr_en     <= 1'b1;
            wr_last   <= (remaining == 1);
            addr      <= addr_next;
            remaining <= remaining - 1'b1;
            if (remaining == 1) begin
              state <= LD_IDLE;
            end
          end
        end
        default: state <= LD_IDLE;
      endcase
    end
  end

  // Write payload
  always_ff @(posedge clk) begin
    if (take) begin
      wr_addr <= addr;
      wr_data <= in_data;
    end
  end

  assign wr = '{en: wr_en, addr: wr_addr, data: wr_data};

  // Every write comes from a byte taken while running
  a_wr_from_run: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr.en |-> $past(state == LD_RUN && in_valid)
  ) else $error("write issued outside LD_RUN");

endmodule

// ==== bram_sdp_shell.sv ====
module bram_sdp_shell #(
  parameter int R_DEPTH      = weight_pkg::R_DEPTH,
  parameter int R_DATA_WIDTH = weight_pkg::R_DATA_WIDTH,
  parameter int W_DATA_WIDTH = weight_pkg::W_DATA_WIDTH,
  parameter int LATENCY      = weight_pkg::RD_LATENCY
) (
  input  logic                       clk,
  input  weight_pkg::wr_req_t        wr,
  input  logic                       rd_en,
  input  logic [$clog2(R_DEPTH)-1:0] rd_addr,
  output logic [R_DATA_WIDTH-1:0]    rd_data
);

  localparam int W_DEPTH = R_DEPTH * R_DATA_WIDTH / W_DATA_WIDTH;

  logic [W_DEPTH-1:0][W_DATA_WIDTH-1:0] cells;
  logic [R_DEPTH-1:0][R_DATA_WIDTH-1:0] words;

  // Narrow write port, one cell per write
  always_ff @(posedge clk) begin
    if (wr.en) begin
      cells[wr.addr] <= wr.data;
    end
  end

  // Wide view of the same bits, lane 0 in the low byte
  assign words = cells;

  n_delay #(
    .N          (LATENCY),
    .WORD_WIDTH (R_DATA_WIDTH)
  ) i_delay (
    .clk      (clk),
    .rst_n    (1'b1),
    .clken    (rd_en),
    .data_in  (words[rd_addr]),
    .data_out (rd_data)
  );

  a_rd_addr_range: assert property (
    @(posedge clk) rd_en |-> (rd_addr < R_DEPTH)
  ) else $error("read address out of range");

endmodule

// ==== weight_reader.sv ====
module weight_reader #(
  parameter int LATENCY = weight_pkg::RD_LATENCY  // 1 or more
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                cmd_valid,
  input  weight_pkg::rd_cmd_t                 cmd,
  output logic                                rd_en,
  output logic [weight_pkg::R_ADDR_WIDTH-1:0] rd_addr,
  input  logic [weight_pkg::R_DATA_WIDTH-1:0] rd_data,
  output logic                                busy,
  output logic                                out_valid,
  output logic [weight_pkg::R_DATA_WIDTH-1:0] out_data,
  output logic                                sum_valid,
  output logic [weight_pkg::SUM_WIDTH-1:0]    sum
);

  import weight_pkg::*;

  localparam int LANES = R_DATA_WIDTH / W_DATA_WIDTH;
  // Only the oldest slot occupied
  localparam logic [LATENCY:1] TRACK_LAST = LATENCY'(1) << (LATENCY - 1);

  read_state_e           state;
  rd_op_e                op_q;
  logic [R_ADDR_WIDTH:0] remaining;
  logic [LATENCY:1]      track;       // One bit per read in flight
  logic [SUM_WIDTH-1:0]  acc;
  logic [SUM_WIDTH-1:0]  lane_total;

  logic accept;
  logic issue;
  logic ret;
  logic stream_done;
  logic sum_done;

  assign accept      = (state == RD_IDLE) && cmd_valid;
  assign issue       = (state == RD_ISSUE);
  assign ret         = track[LATENCY];  // Marked word on rd_data now
  assign stream_done = (state == RD_DRAIN) && (op_q == OP_STREAM) && (track == TRACK_LAST);
  assign sum_done    = (state == RD_DRAIN) && (op_q == OP_SUM) && (track == '0);

  assign rd_en = (state != RD_IDLE);
  assign busy  = (state != RD_IDLE);

  always_comb begin
    lane_total = '0;
    for (int l = 0; l < LANES; l++) begin
      lane_total += SUM_WIDTH'(rd_data[l*W_DATA_WIDTH +: W_DATA_WIDTH]);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= RD_IDLE;
      remaining <= '0;
      track     <= '0;
      out_valid <= 1'b0;
      sum_valid <= 1'b0;
    end else begin
      out_valid <= ret && (op_q == OP_STREAM);
      sum_valid <= 1'b0;
      if (rd_en) begin
        track[1] <= issue;
        for (int j = 2; j <= LATENCY; j++) begin
          track[j] <= track[j-1];
        end
      end
      case (state)
        RD_IDLE: begin
          if (cmd_valid) begin
            remaining <= cmd.count;
            state     <= RD_ISSUE;
          end
        end
        RD_ISSUE: begin
          remaining <= remaining - 1'b1;
          if (remaining == 1) begin
            state <= RD_DRAIN;
          end
        end
        RD_DRAIN: begin
          if (stream_done) begin
            state <= RD_IDLE;  // Last word leaves this edge
          end
          if (sum_done) begin
            sum_valid <= 1'b1;
            state     <= RD_IDLE;
          end
        end
        default: state <= RD_IDLE;
      endcase
    end
  end

  // Address, op and datapath
  always_ff @(posedge clk) begin
    if (accept) begin
      rd_addr <= cmd.addr;
      op_q    <= cmd.op;
    end else if (issue) begin
      rd_addr <= rd_addr + 1'b1;
    end
    if (accept) begin
      acc <= '0;
    end else if (ret && op_q == OP_SUM) begin
      acc <= acc + lane_total;
    end
    if (ret) begin
      out_data <= rd_data;
    end
    if (sum_done) begin
      sum <= acc;
    end
  end

  a_one_result: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(out_valid && sum_valid)
  ) else $error("stream and sum results at once");

  a_cmd_count: assert property (
    @(posedge clk) disable iff (!rst_n)
    accept |-> (cmd.count != '0)
  ) else $error("accepted command with zero count");

endmodule

// ==== weight_buffer_top.sv ====
module weight_buffer_top #(
  parameter int RD_LATENCY = weight_pkg::RD_LATENCY
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                load_start,
  input  logic [weight_pkg::W_ADDR_WIDTH-1:0] load_base,
  input  logic [weight_pkg::W_ADDR_WIDTH:0]   load_count,
  input  logic                                in_valid,
  input  logic [weight_pkg::W_DATA_WIDTH-1:0] in_data,
  output logic                                load_done,
  input  logic                                cmd_valid,
  input  weight_pkg::rd_cmd_t                 cmd,
  output logic                                busy,
  output logic                                out_valid,
  output logic [weight_pkg::R_DATA_WIDTH-1:0] out_data,
  output logic                                sum_valid,
  output logic [weight_pkg::SUM_WIDTH-1:0]    sum
);

  import weight_pkg::*;

  wr_req_t                 wr;
  logic                    rd_en;
  logic [R_ADDR_WIDTH-1:0] rd_addr;
  logic [R_DATA_WIDTH-1:0] rd_data;

  weight_loader i_loader (
    .clk        (clk),
    .rst_n      (rst_n),
    .load_start (load_start),
    .load_base  (load_base),
    .load_count (load_count),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .wr         (wr),
    .load_done  (load_done)
  );

  bram_sdp_shell #(
    .R_DEPTH      (R_DEPTH),
    .R_DATA_WIDTH (R_DATA_WIDTH),
    .W_DATA_WIDTH (W_DATA_WIDTH),
    .LATENCY      (RD_LATENCY)
  ) i_shell (
    .clk     (clk),
    .wr      (wr),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  // Same latency on both sides so the tracker lines up with the data
  weight_reader #(
    .LATENCY (RD_LATENCY)
  ) i_reader (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .busy      (busy),
    .out_valid (out_valid),
    .out_data  (out_data),
    .sum_valid (sum_valid),
    .sum       (sum)
  );

endmodule

// ==== tb_weight_buffer.sv ====
module tb_weight_buffer;

  timeunit 1ns;
  timeprecision 1ps;

  import weight_pkg::*;

  localparam int LATENCY = 2;
  localparam int LANES   = R_DATA_WIDTH / W_DATA_WIDTH;

  logic                    clk;
  logic                    rst_n;
  logic                    load_start;
  logic [W_ADDR_WIDTH-1:0] load_base;
  logic [W_ADDR_WIDTH:0]   load_count;
  logic                    in_valid;
  logic [W_DATA_WIDTH-1:0] in_data;
  logic                    load_done;
  logic                    cmd_valid;
  rd_cmd_t                 cmd;
  logic                    busy;
  logic                    out_valid;
  logic [R_DATA_WIDTH-1:0] out_data;
  logic                    sum_valid;
  logic [SUM_WIDTH-1:0]    sum;

  logic                    last_byte;  // Marks the final strobe of a load
  logic [W_DATA_WIDTH-1:0] model [W_DEPTH];
  integer                  seed;
  int                      errors;
  int                      tests;

  // Expectations for the command in progress
  int     cyc;
  int     acc_cyc;
  int     exp_addr;
  int     exp_count;
  int     exp_sum;
  int     got;
  rd_op_e exp_op;

  weight_buffer_top #(
    .RD_LATENCY (LATENCY)
  ) i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .load_start (load_start),
    .load_base  (load_base),
    .load_count (load_count),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .load_done  (load_done),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .busy       (busy),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .sum_valid  (sum_valid),
    .sum        (sum)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Lane 0 holds the lowest byte address of the word
  function automatic logic [R_DATA_WIDTH-1:0] model_word(input int idx);
    logic [R_DATA_WIDTH-1:0] w;
    int                      l;
    for (l = 0; l < LANES; l++) begin
      w[l*W_DATA_WIDTH +: W_DATA_WIDTH] = model[(idx % R_DEPTH) * LANES + l];
    end
    return w;
  endfunction

  function automatic int range_sum(input int addr, input int count);
    int total;
    int b;
    total = 0;
    for (b = addr * LANES; b < (addr + count) * LANES; b++) begin
      total += model[b % W_DEPTH];
    end
    return total;
  endfunction

  always @(posedge clk) begin
    if (!rst_n) begin
      cyc       <= 0;
      acc_cyc   <= 0;
      exp_addr  <= 0;
      exp_count <= 0;
      exp_sum   <= 0;
      got       <= 0;
      exp_op    <= OP_STREAM;
    end else begin
      cyc <= cyc + 1;
      if (cmd_valid && !busy) begin  // Accepting edge
        acc_cyc   <= cyc;
        exp_op    <= cmd.op;
        exp_addr  <= cmd.addr;
        exp_count <= cmd.count;
        exp_sum   <= range_sum(cmd.addr, cmd.count);
        got       <= 0;
      end else if (out_valid) begin
        got <= got + 1;
      end
    end
  end

  a_reset_quiet: assert property (@(posedge clk)
    $past(!rst_n) |-> !(load_done || busy || out_valid || sum_valid))
  else begin
    errors++;
    $display("error %0t: output active during or right after reset", $time);
  end

  a_load_done_cause: assert property (@(posedge clk) disable iff (!rst_n)
    load_done |-> $past(in_valid && last_byte, 2))
  else begin
    errors++;
    $display("error %0t: load_done without a matching last byte", $time);
  end

  a_load_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    $past(in_valid && last_byte, 2) |-> load_done)
  else begin
    errors++;
    $display("error %0t: load_done missing after last byte", $time);
  end

  a_busy_rise: assert property (@(posedge clk) disable iff (!rst_n)
    $past(cmd_valid && !busy) |-> busy)
  else begin
    errors++;
    $display("error %0t: busy did not rise after accepted command", $time);
  end

  a_stream_owned: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> (exp_op == OP_STREAM) && (got < exp_count))
  else begin
    errors++;
    $display("error %0t: unexpected stream word %0d", $time, got);
  end

  // Sampled one edge after the word appears
  a_stream_time: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> cyc == acc_cyc + LATENCY + 2 + got)
  else begin
    errors++;
    $display("error %0t: stream word %0d off its slot", $time, got);
  end

  a_stream_data: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> out_data == model_word(exp_addr + got))
  else begin
    errors++;
    $display("error %0t: stream word %0d is %h, expected %h", $time, got, out_data,
             model_word(exp_addr + got));
  end

  a_stream_end: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(busy) && exp_op == OP_STREAM |-> out_valid && got == exp_count - 1)
  else begin
    errors++;
    $display("error %0t: busy fell after %0d of %0d words", $time, got, exp_count);
  end

  a_sum_value: assert property (@(posedge clk) disable iff (!rst_n)
    sum_valid |-> exp_op == OP_SUM && sum == SUM_WIDTH'(exp_sum))
  else begin
    errors++;
    $display("error %0t: sum is %0d, expected %0d", $time, sum, exp_sum);
  end

  a_sum_time: assert property (@(posedge clk) disable iff (!rst_n)
    sum_valid |-> $fell(busy) && cyc == acc_cyc + exp_count + LATENCY + 2)
  else begin
    errors++;
    $display("error %0t: sum_valid off its slot or busy not falling with it", $time);
  end

  a_sum_once: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(busy) && exp_op == OP_SUM |-> sum_valid)
  else begin
    errors++;
    $display("error %0t: sum command ended without sum_valid", $time);
  end

  task automatic load_bytes(input int base, input int n, input int gap_max);
    int a;
    int k;
    int gap;
    @(negedge clk);
    load_start = 1'b1;
    load_base  = W_ADDR_WIDTH'(base);
    load_count = (W_ADDR_WIDTH + 1)'(n);
    @(negedge clk);
    load_start = 1'b0;
    a = base;
    for (k = 0; k < n; k++) begin
      in_valid  = 1'b1;
      in_data   = W_DATA_WIDTH'($random(seed));
      last_byte = (k == n - 1);
      model[a]  = in_data;
      a = (a + 1) % W_DEPTH;
      @(negedge clk);
      in_valid  = 1'b0;
      last_byte = 1'b0;
      gap = ($random(seed) & 32'h7fff_ffff) % (gap_max + 1);
      if (k < n - 1) begin
        repeat (gap) @(negedge clk);
      end
    end
  endtask

  task automatic wait_load_done(input int max_cycles);
    int n;
    n = 0;
    while (!load_done && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    if (!load_done) begin
      errors++;
      $display("timeout: load_done never pulsed within %0d cycles", max_cycles);
    end
  endtask

  task automatic send_cmd(input rd_op_e op, input int addr, input int count);
    @(negedge clk);
    cmd_valid = 1'b1;
    cmd.op    = op;
    cmd.addr  = R_ADDR_WIDTH'(addr);
    cmd.count = (R_ADDR_WIDTH + 1)'(count);
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  task automatic wait_idle(input int max_cycles, input string what);
    int n;
    n = 0;
    while (busy && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    if (busy) begin
      errors++;
      $display("timeout: %s still busy after %0d cycles", what, max_cycles);
    end
  endtask

  task automatic end_test(input string name);
    repeat (2) @(negedge clk);  // Let the last results be sampled
    tests++;
    $display("test %0d %s finished, %0d errors so far", tests, name, errors);
  endtask

  initial begin
    int start;
    int count;
    seed       = 97;
    errors     = 0;
    tests      = 0;
    rst_n      = 1'b0;
    load_start = 1'b0;
    load_base  = '0;
    load_count = '0;
    in_valid   = 1'b0;
    in_data    = '0;
    last_byte  = 1'b0;
    cmd_valid  = 1'b0;
    cmd        = '0;
    for (int i = 0; i < W_DEPTH; i++) begin
      model[i] = '0;
    end

    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    end_test("reset state");

    load_bytes(0, W_DEPTH, 3);
    wait_load_done(20);
    end_test("full load");

    send_cmd(OP_STREAM, 0, R_DEPTH);
    wait_idle(R_DEPTH + 20, "full stream");
    end_test("stream readback");

    start = ($random(seed) & 32'h7fff_ffff) % 12;
    count = 2 + ($random(seed) & 32'h7fff_ffff) % (14 - start);  // Partial run inside the array
    send_cmd(OP_SUM, start, count);
    wait_idle(R_DEPTH + 20, "lane sum");
    end_test("lane sum");

    send_cmd(OP_STREAM, 4, 8);
    repeat (3) @(negedge clk);
    cmd_valid = 1'b1;  // Dropped while the reader is busy
    cmd.op    = OP_SUM;
    cmd.addr  = '0;
    cmd.count = (R_ADDR_WIDTH + 1)'(R_DEPTH);
    @(negedge clk);
    cmd_valid = 1'b0;
    wait_idle(R_DEPTH + 20, "stream with ignored command");
    end_test("command during busy");

    load_bytes(21, 6, 2);
    wait_load_done(20);
    send_cmd(OP_STREAM, 0, R_DEPTH);
    wait_idle(R_DEPTH + 20, "stream after reload");
    end_test("partial reload");

    $display("tests run %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== list.f ====
weight_pkg.sv
n_delay.sv
weight_loader.sv
bram_sdp_shell.sv
weight_reader.sv
weight_buffer_top.sv
tb_weight_buffer.sv

// ==== Makefile ====
# Verilator simulation of the weight buffer

VERILATOR ?= verilator
TOP       ?= tb_weight_buffer
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= No errors

.PHONY: sim clean

# Pass or fail comes from the log, not from the simulator exit code
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
